// ==== rtl/lsu_pkg.sv ====
package lsu_pkg;

  // Data and address width
  localparam int XLEN   = 32;

  // One enable per byte lane of a bus word
  localparam int BE_W   = XLEN / 8;

  // Byte offset inside a word
  localparam int OFFS_W = 2;

  // Access size code
  localparam int SIZE_W = 2;

  localparam logic [SIZE_W-1:0] SIZE_BYTE = 2'd0;
  localparam logic [SIZE_W-1:0] SIZE_HALF = 2'd1;
  localparam logic [SIZE_W-1:0] SIZE_WORD = 2'd2;

  ///////////////////////////////////////////////////////////////////////
  // Read-data word as seen by the align stage
  ///////////////////////////////////////////////////////////////////////

  // Byte view serves byte loads and split joins
  // Halfword view serves naturally aligned halfword loads
  typedef union packed {
    logic [BE_W-1:0][7:0] lanes_b;
    logic [1:0][15:0]     lanes_h;
  } mem_word_u;

endpackage

// ==== rtl/lsu_req_if.sv ====
`timescale 1ns/1ps

// Request from the address stage towards the bus stage
interface lsu_req_if import lsu_pkg::*; ();

  logic              valid;
  logic              ready;
  logic [XLEN-1:0]   addr;
  logic              we;
  logic [BE_W-1:0]   be;
  logic [XLEN-1:0]   wdata;
  logic [SIZE_W-1:0] size;
  logic              sign_ext;
  // Original byte offset, the same for both halves of a split
  logic [OFFS_W-1:0] offset;
  // Low only for the first half of a split
  logic              last;

  modport addr_mp (output valid, addr, we, be, wdata, size, sign_ext, offset, last,
                   input  ready);

  modport bus_mp  (input  valid, addr, we, be, wdata, size, sign_ext, offset, last,
                   output ready);

endinterface

// ==== rtl/lsu_resp_if.sv ====
`timescale 1ns/1ps

// Response from the bus stage towards the align stage
interface lsu_resp_if import lsu_pkg::*; ();

  // One-cycle pulse per bus response, cannot be stalled
  logic              valid;
  logic [XLEN-1:0]   rdata;

  // Tag of the transfer this response belongs to
  logic              we;
  logic [SIZE_W-1:0] size;
  logic              sign_ext;
  logic [OFFS_W-1:0] offset;
  logic              last;

  modport bus_mp   (output valid, rdata, we, size, sign_ext, offset, last);

  modport align_mp (input  valid, rdata, we, size, sign_ext, offset, last);

endinterface

// ==== rtl/lsu_addr_stage.sv ====
`timescale 1ns/1ps

module lsu_addr_stage import lsu_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,

  // Access from the core
  input  logic              valid_i,
  input  logic [XLEN-1:0]   addr_i,
  input  logic              we_i,
  input  logic [SIZE_W-1:0] size_i,
  input  logic              sign_ext_i,
  input  logic [XLEN-1:0]   wdata_i,
  output logic              ready_o,

  // Towards the bus stage
  lsu_req_if.addr_mp        req
);

  logic [OFFS_W-1:0] offset;
  logic              is_split;
  // High during the second address phase of a split
  logic              split_q;
  logic [XLEN-1:0]   addr_next_word;
  logic [BE_W-1:0]   be_base;
  // Byte enables of both phases side by side
  logic [2*BE_W-1:0] be_span;
  logic [XLEN-1:0]   wdata_rot;

  assign offset = addr_i[OFFS_W-1:0];

  // Word at any nonzero offset, or halfword in the top lane
  assign is_split = ((size_i == SIZE_WORD) && (offset != 2'd0)) ||
                    ((size_i == SIZE_HALF) && (offset == 2'd3));

  // Second phase starts at the next word
  assign addr_next_word = {addr_i[XLEN-1:OFFS_W], {OFFS_W{1'b0}}} + XLEN'(BE_W);

  ///////////////////////////////////////////////////////////////////////
  // Byte enables
  ///////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (size_i)
      SIZE_BYTE: be_base = 4'b0001;
      SIZE_HALF: be_base = 4'b0011;
      default:   be_base = 4'b1111;
    endcase
  end

  // Lanes shifted past the top of the word belong to the second phase
  assign be_span = {{BE_W{1'b0}}, be_base} << offset;

  // Store data rotated so that byte 0 lands on the addressed lane
  always_comb
  begin
    case (offset)
      2'd1:    wdata_rot = {wdata_i[23:0], wdata_i[31:24]};
      2'd2:    wdata_rot = {wdata_i[15:0], wdata_i[31:16]};
      2'd3:    wdata_rot = {wdata_i[7:0],  wdata_i[31:8]};
      default: wdata_rot = wdata_i;
    endcase
  end

  assign req.valid    = valid_i;
  assign req.addr     = split_q ? addr_next_word : addr_i;
  assign req.be       = split_q ? be_span[2*BE_W-1:BE_W] : be_span[BE_W-1:0];
  assign req.wdata    = wdata_rot;
  assign req.we       = we_i;
  assign req.size     = size_i;
  assign req.sign_ext = sign_ext_i;
  assign req.offset   = offset;
  assign req.last     = !is_split || split_q;

  // Core sees the access done only with the grant of its last phase
  assign ready_o = req.ready && req.last;

  // Phase flag, dropped whenever the core withdraws the access
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      split_q <= 1'b0;
    else if (!valid_i)
      split_q <= 1'b0;
    else if (req.valid && req.ready)
      split_q <= !req.last;
  end

  // Second phase only ever follows the first half of a held split access
  assert property (@(posedge clk) disable iff (!rst_n)
                   split_q |-> (valid_i && is_split));

endmodule

// ==== rtl/lsu_bus_stage.sv ====
`timescale 1ns/1ps

module lsu_bus_stage import lsu_pkg::*;
#(
  parameter int DEPTH = 2
)
(
  input  logic            clk,
  input  logic            rst_n,

  lsu_req_if.bus_mp       req,
  lsu_resp_if.bus_mp      resp,

  // OBI data bus
  output logic            data_req_o,
  input  logic            data_gnt_i,
  output logic [XLEN-1:0] data_addr_o,
  output logic            data_we_o,
  output logic [BE_W-1:0] data_be_o,
  output logic [XLEN-1:0] data_wdata_o,
  input  logic            data_rvalid_i,
  input  logic [XLEN-1:0] data_rdata_i,

  output logic            busy_o
);

  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  // we, size, sign_ext, offset, last
  localparam int TAG_W = 1 + SIZE_W + 1 + OFFS_W + 1;

  localparam logic [CNT_W-1:0] CNT_MAX  = CNT_W'(DEPTH);
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);

  logic [CNT_W-1:0] cnt_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [TAG_W-1:0] tag_q [DEPTH];
  logic             push;
  logic             pop;

  ///////////////////////////////////////////////////////////////////////
  // Address phase
  ///////////////////////////////////////////////////////////////////////

  // Request held back once DEPTH transfers are in flight
  assign data_req_o   = req.valid && (cnt_q < CNT_MAX);
  assign data_addr_o  = req.addr;
  assign data_we_o    = req.we;
  assign data_be_o    = req.be;
  assign data_wdata_o = req.wdata;

  assign req.ready = data_req_o && data_gnt_i;

  assign push = req.valid && req.ready;
  assign pop  = data_rvalid_i;

  // Outstanding transfer count
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      cnt_q <= '0;
    else
    begin
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Queue pointers
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
      if (pop)
        rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
    end
  end

  // Tag storage
  always_ff @(posedge clk)
  begin
    if (push)
      tag_q[wr_ptr_q] <= {req.we, req.size, req.sign_ext, req.offset, req.last};
  end

  ///////////////////////////////////////////////////////////////////////
  // Response phase, in order
  ///////////////////////////////////////////////////////////////////////

  assign resp.valid = data_rvalid_i;
  assign resp.rdata = data_rdata_i;
  assign {resp.we, resp.size, resp.sign_ext, resp.offset, resp.last} = tag_q[rd_ptr_q];

  assign busy_o = (cnt_q != '0) || req.valid;

  // Bus never answers a transfer it did not grant
  assert property (@(posedge clk) disable iff (!rst_n) data_rvalid_i |-> (cnt_q != '0));

  assert property (@(posedge clk) disable iff (!rst_n) cnt_q <= CNT_MAX);

endmodule

// ==== rtl/lsu_align_stage.sv ====
`timescale 1ns/1ps

module lsu_align_stage import lsu_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,

  lsu_resp_if.align_mp    resp,

  output logic            result_valid_o,
  output logic [XLEN-1:0] rdata_o
);

  mem_word_u       rword;
  logic [XLEN-1:0] first_q;
  // A first half has arrived and its second half is awaited
  logic            half_q;
  logic            is_split;
  logic [7:0]      byte_val;
  logic [15:0]     half_val;
  logic [XLEN-1:0] word_val;

  assign rword = resp.rdata;

  assign is_split = ((resp.size == SIZE_WORD) && (resp.offset != 2'd0)) ||
                    ((resp.size == SIZE_HALF) && (resp.offset == 2'd3));

  // Byte lane straight from the word
  assign byte_val = rword.lanes_b[resp.offset];

  always_comb
  begin
    if (resp.offset == 2'd3)
      half_val = {rword.lanes_b[0], first_q[31:24]};
    else if (!resp.offset[0])
      half_val = rword.lanes_h[resp.offset[1]];
    else
      half_val = {rword.lanes_b[2], rword.lanes_b[1]};  // middle lanes, no split
  end

  // Upper part from the new word, lower part from the held first half
  always_comb
  begin
    case (resp.offset)
      2'd1:    word_val = {rword.lanes_b[0], first_q[31:8]};
      2'd2:    word_val = {rword.lanes_h[0], first_q[31:16]};
      2'd3:    word_val = {resp.rdata[23:0], first_q[31:24]};
      default: word_val = resp.rdata;
    endcase
  end

  // Zero or sign extension
  always_comb
  begin
    case (resp.size)
      SIZE_BYTE: rdata_o = {{(XLEN-8){resp.sign_ext && byte_val[7]}}, byte_val};
      SIZE_HALF: rdata_o = {{(XLEN-16){resp.sign_ext && half_val[15]}}, half_val};
      default:   rdata_o = word_val;
    endcase
  end

  // First half of a split produces no result
  assign result_valid_o = resp.valid && resp.last;

  always_ff @(posedge clk)
  begin
    if (resp.valid && !resp.last && !resp.we)
      first_q <= resp.rdata;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      half_q <= 1'b0;
    else if (resp.valid)
      half_q <= !resp.last;
  end

  // First half is always completed by the second half of the same split
  assert property (@(posedge clk) disable iff (!rst_n)
                   resp.valid |-> (half_q == (resp.last && is_split)));

endmodule

// ==== rtl/lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*;
#(
  parameter int DEPTH = 2
)
(
  input  logic              clk,
  input  logic              rst_n,

  // Core request side
  input  logic              valid_i,
  input  logic [XLEN-1:0]   addr_i,
  input  logic              we_i,
  input  logic [SIZE_W-1:0] size_i,
  input  logic              sign_ext_i,
  input  logic [XLEN-1:0]   wdata_i,
  output logic              ready_o,

  // OBI data bus
  output logic              data_req_o,
  input  logic              data_gnt_i,
  output logic [XLEN-1:0]   data_addr_o,
  output logic              data_we_o,
  output logic [BE_W-1:0]   data_be_o,
  output logic [XLEN-1:0]   data_wdata_o,
  input  logic              data_rvalid_i,
  input  logic [XLEN-1:0]   data_rdata_i,

  // Core result side
  output logic              result_valid_o,
  output logic [XLEN-1:0]   rdata_o,
  output logic              busy_o
);

  lsu_req_if  req_if ();
  lsu_resp_if resp_if ();

  ///////////////////////////////////////////////////////////////////////
  // Stages
  ///////////////////////////////////////////////////////////////////////

  lsu_addr_stage u_addr_stage
  (
    .clk        (clk),
    .rst_n      (rst_n),
    .valid_i    (valid_i),
    .addr_i     (addr_i),
    .we_i       (we_i),
    .size_i     (size_i),
    .sign_ext_i (sign_ext_i),
    .wdata_i    (wdata_i),
    .ready_o    (ready_o),
    .req        (req_if.addr_mp)
  );

  lsu_bus_stage #(
    .DEPTH (DEPTH)
  ) u_bus_stage
  (
    .clk           (clk),
    .rst_n         (rst_n),
    .req           (req_if.bus_mp),
    .resp          (resp_if.bus_mp),
    .data_req_o    (data_req_o),
    .data_gnt_i    (data_gnt_i),
    .data_addr_o   (data_addr_o),
    .data_we_o     (data_we_o),
    .data_be_o     (data_be_o),
    .data_wdata_o  (data_wdata_o),
    .data_rvalid_i (data_rvalid_i),
    .data_rdata_i  (data_rdata_i),
    .busy_o        (busy_o)
  );

  lsu_align_stage u_align_stage
  (
    .clk            (clk),
    .rst_n          (rst_n),
    .resp           (resp_if.align_mp),
    .result_valid_o (result_valid_o),
    .rdata_o        (rdata_o)
  );

endmodule

// ==== tb/tb_lsu_checks.svh ====
`ifndef TB_LSU_CHECKS_SVH
`define TB_LSU_CHECKS_SVH

///////////////////////////////////////////////////////////////////////
// Failure reporting
///////////////////////////////////////////////////////////////////////

// Ends the run at the first failure
task automatic fail_run(input string why);
  $display("%s", why);
  $display(">>> FAIL");
  $fatal(1, "Run stopped by a failed check");
endtask

// ERR line with time, signal name, expected and actual value
task automatic report_mismatch(input string name, input logic [XLEN-1:0] exp,
                               input logic [XLEN-1:0] act);
  fail_run($sformatf("ERR %0t %s expected %0h actual %0h", $time, name, exp, act));
endtask

///////////////////////////////////////////////////////////////////////
// Compare tasks, one per kind of result
///////////////////////////////////////////////////////////////////////

// Load results
task automatic check_word(input string name, input logic [XLEN-1:0] exp,
                          input logic [XLEN-1:0] act);
  if (act !== exp)
    report_mismatch(name, exp, act);
endtask

// Byte enables of one bus transfer
task automatic check_be(input string name, input logic [BE_W-1:0] exp,
                        input logic [BE_W-1:0] act);
  if (act !== exp)
    report_mismatch(name, XLEN'(exp), XLEN'(act));
endtask

// Bus address of one transfer
task automatic check_addr(input string name, input logic [XLEN-1:0] exp,
                          input logic [XLEN-1:0] act);
  if (act !== exp)
    report_mismatch(name, exp, act);
endtask

// Handshake and status bits
task automatic check_flag(input string name, input logic exp, input logic act);
  if (act !== exp)
    report_mismatch(name, XLEN'(exp), XLEN'(act));
endtask

`endif

// ==== tb/tb_lsu.sv ====
`timescale 1ns/1ps

module tb_lsu import lsu_pkg::*; ();

  localparam int DEPTH    = 2;
  localparam int N_OPS    = 400;
  // Word stores, then word loads of the same words
  localparam int N_DIRECT = 16;
  localparam int MAX_CYC  = N_OPS * 12;

  logic              clk = 1'b0;
  logic              rst_n;
  logic              valid_i;
  logic [XLEN-1:0]   addr_i;
  logic              we_i;
  logic [SIZE_W-1:0] size_i;
  logic              sign_ext_i;
  logic [XLEN-1:0]   wdata_i;
  logic              ready_o;
  logic              data_req_o;
  logic              data_gnt_i;
  logic [XLEN-1:0]   data_addr_o;
  logic              data_we_o;
  logic [BE_W-1:0]   data_be_o;
  logic [XLEN-1:0]   data_wdata_o;
  logic              data_rvalid_i;
  logic [XLEN-1:0]   data_rdata_i;
  logic              result_valid_o;
  logic [XLEN-1:0]   rdata_o;
  logic              busy_o;

  logic [15:0]       lfsr = 16'd54908;
  // Bus memory and the model's own copy
  logic [7:0]        mem     [128];
  logic [7:0]        ref_mem [128];
  // Responses owed by the bus, in grant order
  logic [XLEN-1:0]   resp_data_q [$];
  int                resp_time_q [$];
  logic              resp_last_q [$];
  // Expected results, in request order
  logic [XLEN-1:0]   exp_q       [$];
  logic              exp_load_q  [$];
  logic [BE_W-1:0]   be0;
  logic [BE_W-1:0]   be1;
  // Store data as it should appear on the bus lanes
  logic [XLEN-1:0]   wd_rot;
  logic              phase;
  logic              active;
  int                ops_started;
  int                out_cnt;
  int                last_resp;
  int                deny_cnt;
  int                cyc;

  `include "tb_lsu_checks.svh"

  always #4 clk = ~clk;

  lsu_top #(
    .DEPTH (DEPTH)
  ) DUT
  (
    .clk            (clk),
    .rst_n          (rst_n),
    .valid_i        (valid_i),
    .addr_i         (addr_i),
    .we_i           (we_i),
    .size_i         (size_i),
    .sign_ext_i     (sign_ext_i),
    .wdata_i        (wdata_i),
    .ready_o        (ready_o),
    .data_req_o     (data_req_o),
    .data_gnt_i     (data_gnt_i),
    .data_addr_o    (data_addr_o),
    .data_we_o      (data_we_o),
    .data_be_o      (data_be_o),
    .data_wdata_o   (data_wdata_o),
    .data_rvalid_i  (data_rvalid_i),
    .data_rdata_i   (data_rdata_i),
    .result_valid_o (result_valid_o),
    .rdata_o        (rdata_o),
    .busy_o         (busy_o)
  );

  ///////////////////////////////////////////////////////////////////////
  // Random source
  ///////////////////////////////////////////////////////////////////////

  // Galois form with polynomial x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);
      bits = {bits[30:0], lfsr[0]};
    end
    return bits;
  endfunction

  ///////////////////////////////////////////////////////////////////////
  // Access generation and reference model
  ///////////////////////////////////////////////////////////////////////

  task automatic start_access();
    logic [1:0]      s;
    logic [XLEN-1:0] val;
    int              n;
    int              k;
    we_i        = draw_bits(1) != 0;
    s           = 2'(draw_bits(2));
    size_i      = (s == 2'd3) ? SIZE_WORD : s;
    sign_ext_i  = draw_bits(1) != 0;
    addr_i      = draw_bits(4) << 2;
    addr_i[1:0] = 2'(draw_bits(2));
    wdata_i     = draw_bits(32);
    if (ops_started < 2 * N_DIRECT)
    begin
      we_i   = ops_started < N_DIRECT;
      size_i = SIZE_WORD;
      addr_i = XLEN'((ops_started % N_DIRECT) * 4);
    end
    n      = (size_i == SIZE_BYTE) ? 1 : (size_i == SIZE_HALF) ? 2 : 4;
    k      = int'(addr_i[1:0]);
    be0    = '0;
    be1    = '0;
    wd_rot = '0;
    val    = '0;
    // Bytes past lane 3 go to the next word
    for (int b = 0; b < n; b++)
    begin
      if (k + b < BE_W)
        be0[k + b] = 1'b1;
      else
        be1[k + b - BE_W] = 1'b1;
      wd_rot[8*((k + b) % BE_W) +: 8] = wdata_i[8*b +: 8];
      val[8*b +: 8] = ref_mem[int'(addr_i[6:0]) + b];
      if (we_i)
        ref_mem[int'(addr_i[6:0]) + b] = wdata_i[8*b +: 8];
    end
    if (sign_ext_i && size_i == SIZE_BYTE && val[7])
      val[XLEN-1:8] = '1;
    if (sign_ext_i && size_i == SIZE_HALF && val[15])
      val[XLEN-1:16] = '1;
    exp_q.push_back(val);
    exp_load_q.push_back(!we_i);
    valid_i = 1'b1;
    phase   = 1'b0;
    active  = 1'b1;
    ops_started++;
  endtask

  // Drive on the falling edge, sample 1 ns later once outputs settle
  task automatic run_cycle();
    logic            grant;
    logic            last_ph;
    logic            req_exp;
    logic [XLEN-1:0] word;
    logic [XLEN-1:0] wmask;
    int              base;
    int              t;
    @(negedge clk);
    cyc++;
    if (cyc > MAX_CYC)
      fail_run("Timeout, the accesses did not finish within the cycle limit");
    if (!active && ops_started < N_OPS)
      start_access();
    else if (!active)
      valid_i = 1'b0;
    // Grant withheld at most three cycles in a row
    data_gnt_i    = (draw_bits(1) != 0) || (deny_cnt == 3);
    deny_cnt      = data_gnt_i ? 0 : deny_cnt + 1;
    data_rvalid_i = (resp_time_q.size() > 0) && (resp_time_q[0] <= cyc);
    data_rdata_i  = data_rvalid_i ? resp_data_q[0] : '0;
    #1;
    // Request only while an access waits and the in-flight count has room
    req_exp = valid_i && (out_cnt < DEPTH);
    grant   = data_req_o && data_gnt_i;
    last_ph = (be1 == '0) || phase;
    check_flag("ready_o", grant && last_ph, ready_o);
    if (grant)
    begin
      check_addr("data_addr_o", phase ? ({addr_i[XLEN-1:2], 2'b00} + 32'd4) : addr_i,
                 data_addr_o);
      check_be("data_be_o", phase ? be1 : be0, data_be_o);
      check_flag("data_we_o", we_i, data_we_o);
      if (we_i)
      begin
        for (int i = 0; i < BE_W; i++)
          wmask[8*i +: 8] = {8{data_be_o[i]}};
        check_word("data_wdata_o", wd_rot & wmask, data_wdata_o & wmask);
      end
      base = int'(data_addr_o[6:2]) * 4;
      for (int i = 0; i < BE_W; i++)
      begin
        if (data_we_o && data_be_o[i])
          mem[base + i] = data_wdata_o[8*i +: 8];
        word[8*i +: 8] = mem[base + i];
      end
      // Responses stay in order, 1 to 3 cycles after the grant
      t = cyc + 1 + int'(draw_bits(2) % 3);
      last_resp = (t > last_resp) ? t : last_resp + 1;
      resp_data_q.push_back(data_we_o ? '0 : word);
      resp_time_q.push_back(last_resp);
      resp_last_q.push_back(last_ph);
      out_cnt++;
      if (out_cnt > DEPTH)
        fail_run("More bus transfers in flight than DEPTH allows");
      phase  = !last_ph;
      active = !last_ph;
    end
    check_flag("data_req_o", req_exp, data_req_o);
    // Only the last phase of an access gives a result
    if (data_rvalid_i)
    begin
      out_cnt--;
      check_flag("result_valid_o", resp_last_q[0], result_valid_o);
      if (resp_last_q[0])
      begin
        if (exp_load_q[0])
          check_word("rdata_o", exp_q[0], rdata_o);
        void'(exp_q.pop_front());
        void'(exp_load_q.pop_front());
      end
      void'(resp_data_q.pop_front());
      void'(resp_time_q.pop_front());
      void'(resp_last_q.pop_front());
    end
    else
      check_flag("result_valid_o", 1'b0, result_valid_o);
  endtask

  ///////////////////////////////////////////////////////////////////////
  // Main sequence
  ///////////////////////////////////////////////////////////////////////

  initial
  begin
    rst_n         = 1'b0;
    valid_i       = 1'b0;
    addr_i        = '0;
    we_i          = 1'b0;
    size_i        = SIZE_BYTE;
    sign_ext_i    = 1'b0;
    wdata_i       = '0;
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_rdata_i  = '0;
    be0           = '0;
    be1           = '0;
    wd_rot        = '0;
    phase         = 1'b0;
    active        = 1'b0;
    ops_started   = 0;
    out_cnt       = 0;
    last_resp     = 0;
    deny_cnt      = 0;
    cyc           = 0;
    // Odd multiplier keeps every byte address distinct
    for (int i = 0; i < 128; i++)
    begin
      mem[i]     = 8'(i * 29 + 7);
      ref_mem[i] = 8'(i * 29 + 7);
    end
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    while (ops_started < N_OPS || active || resp_time_q.size() > 0)
      run_cycle();
    // One idle cycle so the count settles before busy_o is looked at
    run_cycle();
    check_flag("busy_o", 1'b0, busy_o);
    $display(">>> PASS");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+tb
rtl/lsu_pkg.sv
rtl/lsu_req_if.sv
rtl/lsu_resp_if.sv
rtl/lsu_addr_stage.sv
rtl/lsu_bus_stage.sv
rtl/lsu_align_stage.sv
rtl/lsu_top.sv
tb/tb_lsu.sv

// ==== run.sh ====
#!/bin/sh
# Build the LSU testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_lsu \
  -Mdir obj_dir -o sim_lsu -f compile.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/sim_lsu
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi
exit 0
